// File: dv/eth_gen_properties.sv
`timescale 1ns/1ns
`default_nettype none

module eth_gen_properties (
   input wire                        clk,
   input wire                        reset,
   input wire                        tx_ready,
   input wire eth_gen_pkg::tx_word_t tx_data,
   input wire                        tx_valid,
   input wire                        tx_sop,
   input wire                        tx_eop,
   input wire eth_gen_pkg::empty_t   tx_empty
);

   int fail_count = 0;   // Failed assertions so far

   // A stalled beat stays put until the sink takes it
   hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data) && $stable(tx_sop) &&
                                   $stable(tx_eop) && $stable(tx_empty)))
      else begin
         fail_count++;
         $error("stream outputs changed while the sink stalled");
      end

   flags_need_valid: assert property (@(posedge clk) disable iff (reset)
      (tx_sop || tx_eop) |-> tx_valid)
      else begin
         fail_count++;
         $error("sop or eop without valid");
      end

   empty_only_at_eop: assert property (@(posedge clk) disable iff (reset)
      !tx_eop |-> (tx_empty == '0))
      else begin
         fail_count++;
         $error("nonzero empty outside the last beat");
      end

   quiet_after_reset: assert property (@(posedge clk) reset |=> !tx_valid)
      else begin
         fail_count++;
         $error("tx_valid high right after reset");
      end

endmodule

bind eth_gen_top eth_gen_properties eth_gen_properties_i (
   .clk      (clk),
   .reset    (reset),
   .tx_ready (tx_ready),
   .tx_data  (tx_data),
   .tx_valid (tx_valid),
   .tx_sop   (tx_sop),
   .tx_eop   (tx_eop),
   .tx_empty (tx_empty)
);

`default_nettype wire

// File: dv/eth_gen_tb.sv
`timescale 1ns/1ns
`include "eth_gen_macros.svh"
`default_nettype none

module eth_gen_tb;
   import eth_gen_pkg::*;

   localparam int NUM_COLS  = 7;    // Words per line of the tests file
   localparam int MAX_TESTS = 32;

   logic                       clk;
   logic                       reset;
   logic [`ETH_GEN_CSR_AW-1:0] address;
   logic                       write;
   logic                       read;
   csr_word_t                  writedata;
   csr_word_t                  readdata;
   logic                       tx_ready;
   tx_word_t                   tx_data;
   logic                       tx_valid;
   logic                       tx_sop;
   logic                       tx_eop;
   empty_t                     tx_empty;

   logic [63:0] tests_mem [0:NUM_COLS*MAX_TESTS-1];
   tx_word_t    rx_data[$];      // Beats seen on the stream
   logic [1:0]  rx_flags[$];     // {sop, eop}
   empty_t      rx_empty[$];
   tx_word_t    ex_data[$];      // Reference beats
   logic [1:0]  ex_flags[$];
   empty_t      ex_empty[$];
   logic [31:0] rng;
   logic        random_ready;
   int          checks;
   int          errors;
   bit          timed_out;

   eth_gen_top eth_gen_top_i (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_sop    (tx_sop),
      .tx_eop    (tx_eop),
      .tx_empty  (tx_empty)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [63:0] field(input int t, input int col);
      return tests_mem[t*NUM_COLS+col];
   endfunction

   // ----------------------------------------
   // Ready driver and stream monitor
   // ----------------------------------------
   always @(posedge clk) begin
      if (random_ready) begin
         rng = xorshift32(rng);
         tx_ready <= rng[7];            // About half the cycles
      end else begin
         tx_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      if (!reset && tx_valid && tx_ready) begin   // Transfer on this edge
         rx_data.push_back(tx_data);
         rx_flags.push_back({tx_sop, tx_eop});
         rx_empty.push_back(tx_empty);
      end
   end

   // ----------------------------------------
   // Register access
   // ----------------------------------------
   task automatic csr_write(input csr_addr_e a, input csr_word_t d);
      @(posedge clk);
      address   <= a;
      writedata <= d;
      write     <= 1'b1;
      @(posedge clk);
      write     <= 1'b0;
   endtask

   task automatic csr_read(input csr_addr_e a, output csr_word_t d);
      @(posedge clk);
      address <= a;
      read    <= 1'b1;
      @(negedge clk);
      d = readdata;                    // Combinational read settles by mid-cycle
      @(posedge clk);
      read    <= 1'b0;
   endtask

   task automatic check_csr(input string what, input csr_word_t got, input csr_word_t exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t: register %s read %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_beat(input int idx, input tx_word_t got_d, input tx_word_t exp_d,
                             input logic [1:0] got_f, input logic [1:0] exp_f,
                             input empty_t got_e, input empty_t exp_e);
      checks++;
      if (got_d !== exp_d || got_f !== exp_f || got_e !== exp_e) begin
         $display("[ERROR] %0t: beat %0d data %h sop/eop %b empty %0d, expected %h %b %0d",
                  $time, idx, got_d, got_f, got_e, exp_d, exp_f, exp_e);
         errors++;
      end
   endtask

   // ----------------------------------------
   // Bounded waits
   // ----------------------------------------
   task automatic wait_beats(input int need, input int limit, output bit ok);
      int cycles;
      cycles = 0;
      while (rx_data.size() < need && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      ok = (rx_data.size() >= need);
      if (!ok) begin
         $display("Timeout: only %0d of %0d beats arrived in %0d cycles",
                  rx_data.size(), need, limit);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_quiet(input int need, input int limit, output bit ok);
      int idle;
      int cycles;
      idle   = 0;
      cycles = 0;
      while (idle < need && cycles < limit) begin
         @(negedge clk);
         idle = tx_valid ? 0 : idle + 1;
         cycles++;
      end
      ok = (idle >= need);
      if (!ok) begin
         $display("Timeout: stream did not go idle within %0d cycles", limit);
         timed_out = 1'b1;
      end
   endtask

   // Expected beats of a run from the frame rule
   task automatic build_expected(input int frames, input logic [13:0] len,
                                 input mac_addr_t dst, input mac_addr_t src, output int per);
      int         l;
      int         pi;
      int         nd;
      tx_word_t   w;
      logic [7:0] base;
      l = int'(len);
      if (l < `ETH_GEN_HDR_BYTES) pi = 0;
      else if (l > `ETH_GEN_MAX_LEN) pi = `ETH_GEN_MAX_LEN - `ETH_GEN_HDR_BYTES;
      else pi = l - `ETH_GEN_HDR_BYTES;
      nd   = (pi + 7) / 8;             // Payload beats per frame
      per  = 2 + nd;
      base = 8'h00;                    // Pattern restarts per run
      for (int f = 0; f < frames; f++) begin
         for (int i = 0; i < 6; i++) w[63-8*i -: 8] = dst[8*i +: 8];
         w[15:8] = src[7:0];
         w[7:0]  = src[15:8];
         ex_data.push_back(w);
         ex_flags.push_back(2'b10);
         ex_empty.push_back(3'd0);
         for (int i = 0; i < 4; i++) w[63-8*i -: 8] = src[8*(i+2) +: 8];
         w[31:16] = len_t'(pi + `ETH_GEN_LEN_ADJ);
         w[15:0]  = 16'(f);            // Sequence number
         ex_data.push_back(w);
         ex_flags.push_back({1'b0, nd == 0});
         ex_empty.push_back(3'd0);
         for (int k = 0; k < nd; k++) begin
            for (int j = 0; j < 8; j++) w[63-8*j -: 8] = base + 8'(j);
            base = base + 8'd8;        // Wraps F8 to 00
            ex_data.push_back(w);
            ex_flags.push_back({1'b0, k == nd - 1});
            ex_empty.push_back((k == nd - 1) ? empty_t'((8 - pi % 8) % 8) : 3'd0);
         end
      end
   endtask

   task automatic compare_beats();
      if (rx_data.size() != ex_data.size()) begin
         $display("[ERROR] %0t: received %0d beats, expected %0d",
                  $time, rx_data.size(), ex_data.size());
         errors++;
      end
      for (int i = 0; i < rx_data.size() && i < ex_data.size(); i++) begin
         check_beat(i, rx_data[i], ex_data[i], rx_flags[i], ex_flags[i],
                    rx_empty[i], ex_empty[i]);
      end
   endtask

   // ----------------------------------------
   // Test kinds
   // ----------------------------------------
   task automatic register_test(input int t);
      logic [63:0] v;
      csr_word_t   num;
      csr_word_t   cfg;
      csr_word_t   rd;
      mac_addr_t   dst;
      mac_addr_t   src;
      v   = field(t, 2);
      num = v[31:0];
      v   = field(t, 3);
      cfg = v[31:0];
      v   = field(t, 4);
      dst = v[47:0];
      v   = field(t, 5);
      src = v[47:0];
      csr_write(CSR_NUM_PKT, num);
      csr_write(CSR_CONFIG, cfg);
      csr_write(CSR_SRC_LO, src[31:0]);
      csr_write(CSR_SRC_HI, {16'hFFFF, src[47:32]});   // Upper half dropped
      csr_write(CSR_DST_LO, dst[31:0]);
      csr_write(CSR_DST_HI, {16'hFFFF, dst[47:32]});
      csr_read(CSR_NUM_PKT, rd);
      check_csr("num_pkt", rd, num);
      csr_read(CSR_CONFIG, rd);
      check_csr("config", rd, cfg & 32'h0000_7FFE);
      csr_read(CSR_SRC_LO, rd);
      check_csr("src_lo", rd, src[31:0]);
      csr_read(CSR_SRC_HI, rd);
      check_csr("src_hi", rd, {16'd0, src[47:32]});
      csr_read(CSR_DST_LO, rd);
      check_csr("dst_lo", rd, dst[31:0]);
      csr_read(CSR_DST_HI, rd);
      check_csr("dst_hi", rd, {16'd0, dst[47:32]});
      for (int a = 0; a < 16; a++) begin
         if (a == 3 || a == 8 || a >= 10) begin      // Unmapped
            csr_read(csr_addr_e'(4'(a)), rd);
            check_csr("unused", rd, '0);
         end
      end
      @(negedge clk);
      check_csr("readdata with read low", readdata, '0);
   endtask

   task automatic frame_run(input int t, input bit stop_mid);
      logic [63:0] v;
      csr_word_t   frames;
      csr_word_t   rd;
      logic [13:0] len;
      mac_addr_t   dst;
      mac_addr_t   src;
      int          per_file;
      int          per_model;
      int          n_frames;
      int          limit;
      bit          ok;
      v        = field(t, 2);
      frames   = v[31:0];
      v        = field(t, 3);
      len      = v[13:0];
      v        = field(t, 4);
      dst      = v[47:0];
      v        = field(t, 5);
      src      = v[47:0];
      v        = field(t, 6);
      per_file = int'(v[15:0]);
      limit    = int'(frames) * per_file * 8 + 2000;
      csr_write(CSR_NUM_PKT, frames);
      csr_write(CSR_CONFIG, {17'd0, len, 1'b0});
      csr_write(CSR_SRC_LO, src[31:0]);
      csr_write(CSR_SRC_HI, {16'd0, src[47:32]});
      csr_write(CSR_DST_LO, dst[31:0]);
      csr_write(CSR_DST_HI, {16'd0, dst[47:32]});
      rx_data.delete();
      rx_flags.delete();
      rx_empty.delete();
      ex_data.delete();
      ex_flags.delete();
      ex_empty.delete();
      v = field(t, 1);
      random_ready <= v[0];
      csr_write(CSR_OPERATION, 32'h1);              // Start bit set and stop bit cleared
      if (stop_mid) begin
         wait_beats(1, 2000, ok);
         if (ok) csr_write(CSR_OPERATION, 32'h2);   // Stop at frame boundary
      end else begin
         wait_beats(int'(frames) * per_file, limit, ok);
      end
      if (ok) wait_quiet(20, limit, ok);
      if (ok) begin
         n_frames = stop_mid ? 1 : int'(frames);   // Stop is written during the first frame
         build_expected(n_frames, len, dst, src, per_model);
         if (per_model != per_file) begin
            $display("Reference model gives %0d beats per frame, tests file says %0d",
                     per_model, per_file);
            errors++;
         end
         compare_beats();
         csr_read(CSR_TX_COUNT, rd);
         check_csr("tx_count", rd, csr_word_t'(n_frames));
         csr_read(CSR_OPERATION, rd);
         check_csr("operation", rd, stop_mid ? 32'h2 : 32'h4);   // Done only without stop
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      csr_word_t   rd;
      logic [63:0] kind;
      int          t;
      int          errs_before;
      int          bad_tests;
      int          assert_fails;
      reset        <= 1'b1;
      address      <= '0;
      write        <= 1'b0;
      read         <= 1'b0;
      writedata    <= '0;
      tx_ready     <= 1'b0;
      random_ready <= 1'b0;
      rng          = 32'h4a98_ef3b;
      checks       = 0;
      errors       = 0;
      bad_tests    = 0;
      timed_out    = 1'b0;
      for (int i = 0; i < NUM_COLS*MAX_TESTS; i++) tests_mem[i] = '0;   // Kind 0 ends the list
      $readmemh("dv/eth_gen_tests.txt", tests_mem);
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      for (int a = 0; a < 16; a++) begin        // Everything reads zero after reset
         csr_read(csr_addr_e'(4'(a)), rd);
         check_csr("after reset", rd, '0);
      end
      $display("reset values: %0d errors", errors);
      if (errors != 0) bad_tests++;

      t = 0;
      while (t < MAX_TESTS && field(t, 0) != 0 && !timed_out) begin
         errs_before = errors;
         kind        = field(t, 0);
         case (kind)
            64'd1: register_test(t);
            64'd2: frame_run(t, 1'b0);
            64'd3: frame_run(t, 1'b1);
            default: begin
               $display("Tests file line %0d has an unknown kind %0d", t, kind);
               errors++;
            end
         endcase
         $display("test %0d kind %0d: %0d beats, %0d errors", t, kind, rx_data.size(),
                  errors - errs_before);
         if (errors != errs_before || timed_out) bad_tests++;
         t++;
      end

      assert_fails = eth_gen_top_i.eth_gen_properties_i.fail_count;
      $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d assertion fails",
               t + 1, bad_tests, checks, errors, assert_fails);
      if (errors == 0 && !timed_out && assert_fails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/eth_gen_tests.txt
// kind mode frames length dst_mac src_mac beats_per_frame (all hex)
// kind 1 registers, 2 frame run, 3 run stopped early; mode 1 random tx_ready
1 0 00012345 FFFFFFFF 0123456789AB CAFE00112233 0
// Mid-range length 100, payload 76
2 0 1 64 665544332211 0C0B0A090807 C
// Short lengths give header-only frames
2 0 2 A A1A2A3A4A5A6 B1B2B3B4B5B6 2
2 0 1 18 0000C0FFEE00 112233445566 2
// Length 12000 clamps to payload 9576
2 0 1 2EE0 FFFFFFFFFFFF 020000000001 4AF
// Five frames, pattern wraps across frames
2 0 5 12C 0180C2000001 001B21ABCDEF 25
2 1 5 12C 0180C2000001 001B21ABCDEF 25
// Odd payload 37 with back-pressure, empty 3
2 1 3 3D 5A5A5A5A5A5A A5A5A5A5A5A5 7
2 1 1 3FFF 010203040506 0A0B0C0D0E0F 4AF
// Stop written after the first beat
3 0 14 C8 123456789ABC 0F0E0D0C0B0A 18
3 1 14 1F4 DEADBEEF0001 00AA00BB00CC 3E

// File: include/eth_gen_macros.svh
`ifndef ETH_GEN_MACROS_SVH
`define ETH_GEN_MACROS_SVH

// Bus widths
`define ETH_GEN_DATA_W 64
`define ETH_GEN_CSR_AW 4
`define ETH_GEN_CSR_W 32

// Frame sizing
// Programmed length that leaves no payload bytes
`define ETH_GEN_HDR_BYTES 24
// Longest programmed length accepted before clamping
`define ETH_GEN_MAX_LEN 9600
// Added to the payload length in the length field of beat 1
`define ETH_GEN_LEN_ADJ 6

// Incrementing payload
`define ETH_GEN_PATTERN_INIT 64'h0001_0203_0405_0607
`define ETH_GEN_PATTERN_STEP 64'h0808_0808_0808_0808

`endif

// File: rtl/eth_gen_pkg.sv
`include "eth_gen_macros.svh"
`default_nettype none

package eth_gen_pkg;

   // Frame FSM states
   typedef enum logic [2:0] {
      ST_IDLE,          // Waiting for start
      ST_DEST_SRC,      // Beat 0, dest + upper src
      ST_SRC_LEN_SEQ,   // Beat 1, lower src + length + seq
      ST_DATA,          // Payload beats
      ST_GAP            // Inter-frame idle
   } gen_state_e;

   // Register map
   typedef enum logic [`ETH_GEN_CSR_AW-1:0] {
      CSR_NUM_PKT   = 4'd0,
      CSR_CONFIG    = 4'd1,
      CSR_OPERATION = 4'd2,
      CSR_SRC_LO    = 4'd4,
      CSR_SRC_HI    = 4'd5,
      CSR_DST_LO    = 4'd6,
      CSR_DST_HI    = 4'd7,
      CSR_TX_COUNT  = 4'd9
   } csr_addr_e;

   typedef logic [`ETH_GEN_DATA_W-1:0] tx_word_t;   // One stream beat
   typedef logic [`ETH_GEN_CSR_W-1:0]  csr_word_t;  // One register value
   typedef logic [2:0]                 empty_t;     // Unused low bytes of last beat
   typedef logic [15:0]                len_t;       // Lengths and byte counts
   typedef logic [47:0]                mac_addr_t;

endpackage

`default_nettype wire

// File: rtl/eth_gen_top.sv
`timescale 1ns/1ns
`include "eth_gen_macros.svh"
`default_nettype none

module eth_gen_top (
   input  wire                         clk,
   input  wire                         reset,
   // Register port
   input  wire [`ETH_GEN_CSR_AW-1:0]   address,
   input  wire                         write,
   input  wire                         read,
   input  wire eth_gen_pkg::csr_word_t writedata,
   output eth_gen_pkg::csr_word_t      readdata,
   // Stream port
   input  wire                         tx_ready,
   output eth_gen_pkg::tx_word_t       tx_data,
   output logic                        tx_valid,
   output logic                        tx_sop,
   output logic                        tx_eop,
   output eth_gen_pkg::empty_t         tx_empty
);

   logic                    start;
   logic                    stop;
   logic                    all_sent;
   logic [13:0]             pkt_length;
   logic                    frame_sent;
   eth_gen_pkg::mac_addr_t  dst_addr;
   eth_gen_pkg::mac_addr_t  src_addr;
   eth_gen_pkg::gen_state_e state;
   eth_gen_pkg::len_t       payload_len;
   logic [15:0]             seq_num;
   logic                    last_beat;
   logic                    advance;

   gen_csr gen_csr_i (
      .clk        (clk),
      .reset      (reset),
      .address    (eth_gen_pkg::csr_addr_e'(address)),
      .write      (write),
      .read       (read),
      .writedata  (writedata),
      .frame_sent (frame_sent),
      .readdata   (readdata),
      .start      (start),
      .stop       (stop),
      .all_sent   (all_sent),
      .pkt_length (pkt_length),
      .dst_addr   (dst_addr),
      .src_addr   (src_addr)
   );

   frame_sequencer frame_sequencer_i (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .stop        (stop),
      .all_sent    (all_sent),
      .pkt_length  (pkt_length),
      .advance     (advance),
      .state       (state),
      .payload_len (payload_len),
      .seq_num     (seq_num),
      .last_beat   (last_beat),
      .frame_sent  (frame_sent)
   );

   frame_datapath frame_datapath_i (
      .clk         (clk),
      .reset       (reset),
      .state       (state),
      .payload_len (payload_len),
      .seq_num     (seq_num),
      .last_beat   (last_beat),
      .dst_addr    (dst_addr),
      .src_addr    (src_addr),
      .tx_ready    (tx_ready),
      .advance     (advance),
      .tx_data     (tx_data),
      .tx_valid    (tx_valid),
      .tx_sop      (tx_sop),
      .tx_eop      (tx_eop),
      .tx_empty    (tx_empty)
   );

endmodule

`default_nettype wire

// File: rtl/frame_datapath.sv
`timescale 1ns/1ns
`include "eth_gen_macros.svh"
`default_nettype none

module frame_datapath (
   input  wire                          clk,
   input  wire                          reset,
   input  wire eth_gen_pkg::gen_state_e state,
   input  wire eth_gen_pkg::len_t       payload_len,
   input  wire [15:0]                   seq_num,
   input  wire                          last_beat,
   input  wire eth_gen_pkg::mac_addr_t  dst_addr,
   input  wire eth_gen_pkg::mac_addr_t  src_addr,
   input  wire                          tx_ready,
   output logic                         advance,
   output eth_gen_pkg::tx_word_t        tx_data,
   output logic                         tx_valid,
   output logic                         tx_sop,
   output logic                         tx_eop,
   output eth_gen_pkg::empty_t          tx_empty
);
   import eth_gen_pkg::*;

   tx_word_t  pattern;     // Next payload word
   tx_word_t  beat_data;
   mac_addr_t dst_w;
   mac_addr_t src_w;
   len_t      len_field;
   empty_t    last_empty;

   // Byte 0 of the register goes out first
   function automatic mac_addr_t wire_order(input mac_addr_t a);
      mac_addr_t r;
      for (int i = 0; i < 6; i++) begin
         r[47-8*i -: 8] = a[8*i +: 8];
      end
      return r;
   endfunction

   assign dst_w      = wire_order(dst_addr);
   assign src_w      = wire_order(src_addr);
   assign len_field  = payload_len + len_t'(`ETH_GEN_LEN_ADJ);
   assign last_empty = 3'd0 - payload_len[2:0];   // (8 - P mod 8) mod 8

   // Move on a transfer, or fill an empty output stage
   assign advance = tx_ready | ~tx_valid;

   // ----------------------------------------
   // Beat assembly
   // ----------------------------------------
   always_comb begin
      case (state)
         ST_DEST_SRC:    beat_data = {dst_w, src_w[47:32]};
         ST_SRC_LEN_SEQ: beat_data = {src_w[31:0], len_field, seq_num};
         default:        beat_data = pattern;
      endcase
   end

   // Pattern restarts on every run and carries across frames
   always_ff @(posedge clk) begin
      if (state == ST_IDLE) begin
         pattern <= `ETH_GEN_PATTERN_INIT;
      end else if (state == ST_DATA && advance) begin
         if (pattern[7:0] == 8'hFF) begin
            pattern <= `ETH_GEN_PATTERN_INIT;   // F8..FF wraps to 00..07
         end else begin
            pattern <= pattern + `ETH_GEN_PATTERN_STEP;
         end
      end
   end

   // ----------------------------------------
   // Stream output stage
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         tx_empty <= '0;
      end else if (advance) begin                  // Hold while sink stalls
         tx_valid <= (state == ST_DEST_SRC) || (state == ST_SRC_LEN_SEQ) ||
                     (state == ST_DATA);
         tx_sop   <= (state == ST_DEST_SRC);
         tx_eop   <= last_beat;
         tx_empty <= last_beat ? last_empty : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         tx_data <= beat_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ns
`include "eth_gen_macros.svh"
`default_nettype none

module frame_sequencer (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    start,
   input  wire                    stop,
   input  wire                    all_sent,
   input  wire [13:0]             pkt_length,
   input  wire                    advance,       // One beat moves per advance
   output eth_gen_pkg::gen_state_e state,
   output eth_gen_pkg::len_t      payload_len,
   output logic [15:0]            seq_num,
   output logic                   last_beat,     // Beat loaded now ends the frame
   output logic                   frame_sent
);
   import eth_gen_pkg::*;

   localparam len_t BEAT_BYTES = len_t'(`ETH_GEN_DATA_W / 8);

   gen_state_e next_state;
   len_t       clamped_len;
   len_t       byte_cnt;       // Payload bytes still to load
   logic       hdr1_out;       // Beat 1 sits on the stream outputs
   logic       gap_flushed;    // Last beat of the frame has left

   // Payload length from programmed length
   always_comb begin
      if (pkt_length < 14'(`ETH_GEN_HDR_BYTES)) begin
         clamped_len = '0;
      end else if (pkt_length > 14'(`ETH_GEN_MAX_LEN)) begin
         clamped_len = len_t'(`ETH_GEN_MAX_LEN - `ETH_GEN_HDR_BYTES);
      end else begin
         clamped_len = len_t'(pkt_length) - len_t'(`ETH_GEN_HDR_BYTES);
      end
   end

   // Decided once here, datapath trusts it
   always_comb begin
      case (state)
         ST_SRC_LEN_SEQ: last_beat = (payload_len == '0);   // Header-only frame
         ST_DATA:        last_beat = (byte_cnt <= BEAT_BYTES);
         default:        last_beat = 1'b0;
      endcase
   end

   // ----------------------------------------
   // Frame FSM
   // ----------------------------------------
   always_comb begin
      next_state = state;
      case (state)
         ST_IDLE: if (start) next_state = ST_DEST_SRC;
         ST_DEST_SRC: if (advance) next_state = ST_SRC_LEN_SEQ;
         ST_SRC_LEN_SEQ: if (advance) next_state = last_beat ? ST_GAP : ST_DATA;
         ST_DATA: if (advance && last_beat) next_state = ST_GAP;
         ST_GAP: begin
            // Count is up to date once the last beat has gone
            if (gap_flushed) next_state = (stop || all_sent) ? ST_IDLE : ST_DEST_SRC;
         end
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state       <= ST_IDLE;
         payload_len <= '0;
         byte_cnt    <= '0;
         hdr1_out    <= 1'b0;
         gap_flushed <= 1'b0;
      end else begin
         state       <= next_state;
         gap_flushed <= (state == ST_GAP) && advance && !gap_flushed;
         if (state == ST_IDLE || state == ST_GAP) begin
            payload_len <= clamped_len;          // Latched between frames
         end
         if (advance) begin
            hdr1_out <= (state == ST_SRC_LEN_SEQ);
            if (state == ST_SRC_LEN_SEQ) begin
               byte_cnt <= payload_len;
            end else if (state == ST_DATA) begin
               byte_cnt <= byte_cnt - BEAT_BYTES;   // Eight bytes per beat
            end
         end
      end
   end

   assign frame_sent = hdr1_out & advance;   // Beat 1 transfers

   // Sequence number, bumped after beat 1 has gone
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         seq_num <= '0;
      end else if (start) begin
         seq_num <= '0;
      end else if (frame_sent) begin
         seq_num <= seq_num + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/gen_csr.sv
`timescale 1ns/1ns
`default_nettype none

module gen_csr (
   input  wire                         clk,
   input  wire                         reset,
   input  wire eth_gen_pkg::csr_addr_e address,
   input  wire                         write,
   input  wire                         read,
   input  wire eth_gen_pkg::csr_word_t writedata,
   input  wire                         frame_sent,   // One pulse per frame from sequencer
   output eth_gen_pkg::csr_word_t      readdata,
   output logic                        start,        // Single-cycle run start
   output logic                        stop,         // Level, honoured at frame boundary
   output logic                        all_sent,
   output logic [13:0]                 pkt_length,
   output eth_gen_pkg::mac_addr_t      dst_addr,
   output eth_gen_pkg::mac_addr_t      src_addr
);
   import eth_gen_pkg::*;

   csr_word_t   num_pkt;     // Frames per run
   csr_word_t   src_lo;
   csr_word_t   dst_lo;
   csr_word_t   tx_count;    // Frames sent this run
   logic [15:0] src_hi;
   logic [15:0] dst_hi;
   logic        op_start;    // Operation bit 0
   logic        op_done;     // Operation bit 2
   logic        start_d;     // For edge detect on bit 0
   logic        armed;       // Set by the first start after reset

   // ----------------------------------------
   // Configuration registers
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_pkt    <= '0;
         pkt_length <= '0;
         src_lo     <= '0;
         src_hi     <= '0;
         dst_lo     <= '0;
         dst_hi     <= '0;
      end else if (write) begin
         case (address)
            CSR_NUM_PKT: num_pkt    <= writedata;
            CSR_CONFIG:  pkt_length <= writedata[14:1];   // Other bits not kept
            CSR_SRC_LO:  src_lo     <= writedata;
            CSR_SRC_HI:  src_hi     <= writedata[15:0];
            CSR_DST_LO:  dst_lo     <= writedata;
            CSR_DST_HI:  dst_hi     <= writedata[15:0];
            default: ;
         endcase
      end
   end

   assign src_addr = {src_hi, src_lo};
   assign dst_addr = {dst_hi, dst_lo};

   // ----------------------------------------
   // Operation register
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         op_start <= 1'b0;
         stop     <= 1'b0;
         op_done  <= 1'b0;
         start_d  <= 1'b0;
         armed    <= 1'b0;
      end else begin
         start_d <= op_start;
         if (write && address == CSR_OPERATION) begin
            op_start <= writedata[0];
            stop     <= writedata[1];
         end else if (start) begin
            op_start <= 1'b0;            // Self-clearing start bit
            op_done  <= 1'b0;
         end else if (armed && all_sent) begin
            op_done  <= 1'b1;
         end
         if (start) begin
            armed <= 1'b1;               // No done before a run was started
         end
      end
   end

   assign start = op_start & ~start_d;   // Rising edge of bit 0

   // Sent-frame counter, cleared by each start
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_count <= '0;
      end else if (start) begin
         tx_count <= '0;
      end else if (frame_sent) begin
         tx_count <= tx_count + 1'b1;
      end
   end

   assign all_sent = (tx_count == num_pkt);

   // Read mux, zero when not reading
   always_comb begin
      readdata = '0;
      if (read) begin
         case (address)
            CSR_NUM_PKT:   readdata = num_pkt;
            CSR_CONFIG:    readdata = {17'd0, pkt_length, 1'b0};
            CSR_OPERATION: readdata = {29'd0, op_done, stop, op_start};
            CSR_SRC_LO:    readdata = src_lo;
            CSR_SRC_HI:    readdata = {16'd0, src_hi};
            CSR_DST_LO:    readdata = dst_lo;
            CSR_DST_HI:    readdata = {16'd0, dst_hi};
            CSR_TX_COUNT:  readdata = tx_count;
            default:       readdata = '0;   // Unmapped addresses
         endcase
      end
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the eth_gen testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module eth_gen_tb \
   -f vlog.f --Mdir obj_dir -o eth_gen_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/eth_gen_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^Test passed$"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: vlog.f
+incdir+include
rtl/eth_gen_pkg.sv
rtl/gen_csr.sv
rtl/frame_sequencer.sv
rtl/frame_datapath.sv
rtl/eth_gen_top.sv
dv/eth_gen_properties.sv
dv/eth_gen_tb.sv
